// ==== logic/lsu_pkg.sv ====
/*
 * RV64 load/store pipe shared definitions
 * Widths, operation encodings, the instruction field views and the
 * records that travel between the EX stages and the memory side
 */
`default_nettype none

package lsu_pkg;

  // ----------------------------------------
  // Widths and opcodes
  // ----------------------------------------
  localparam int XLEN_W   = 64;
  localparam int ADDR_W   = 32;
  localparam int DW_BYTES = 8;
  localparam int RNID_W   = 6;
  localparam int REGIDX_W = 5;
  localparam int CMT_ID_W = 6;

  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef enum logic [1:0] {
    OP_LOAD  = 2'd0,
    OP_STORE = 2'd1,
    OP_OTHER = 2'd2
  } lsu_op_e;

  // Same encoding as funct3[1:0]
  typedef enum logic [1:0] {
    SIZE_B  = 2'd0,
    SIZE_H  = 2'd1,
    SIZE_W  = 2'd2,
    SIZE_DW = 2'd3
  } lsu_size_e;

  typedef enum logic [1:0] {
    EXC_NONE            = 2'd0,
    LOAD_ADDR_MISALIGN  = 2'd1,
    STAMO_ADDR_MISALIGN = 2'd2
  } except_e;

  // ----------------------------------------
  // Instruction word views
  // ----------------------------------------
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } load_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } store_fmt_t;

  // One word, two field layouts for the offset
  typedef union packed {
    load_fmt_t  ld;
    store_fmt_t st;
  } lsu_inst_u;

  typedef struct packed {
    lsu_op_e   op;
    lsu_size_e size;
    logic      is_unsigned;
  } lsu_ctrl_t;

  // ----------------------------------------
  // External records
  // ----------------------------------------
  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
    lsu_inst_u           inst;
    logic [XLEN_W-1:0]   rs1_data;
    logic                wr_valid;
    logic [RNID_W-1:0]   wr_rnid;
    logic [REGIDX_W-1:0] wr_regidx;
  } lsu_issue_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] paddr;
  } l1d_req_t;

  typedef struct packed {
    logic                valid;
    logic [ADDR_W-1:0]   paddr;
    logic [DW_BYTES-1:0] dw;
  } fwd_req_t;

  // fwd_dw is in word byte lanes, data starts at the load's first byte
  typedef struct packed {
    logic [DW_BYTES-1:0] fwd_dw;
    logic [XLEN_W-1:0]   data;
  } fwd_resp_t;

  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
    logic [ADDR_W-1:0]   paddr;
    lsu_size_e           size;
  } stq_upd_t;

  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
    logic                except_valid;
    except_e             except_type;
    logic [XLEN_W-1:0]   tval;
  } done_report_t;

  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rnid;
    logic [XLEN_W-1:0] data;
  } phy_wr_t;

  // ----------------------------------------
  // Stage records
  // ----------------------------------------
  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
    lsu_ctrl_t           ctrl;
    logic [ADDR_W-1:0]   paddr;
    logic                except_valid;
    except_e             except_type;
    logic                wr_valid;
    logic [RNID_W-1:0]   wr_rnid;
    logic [REGIDX_W-1:0] wr_regidx;
  } ex1_entry_t;

  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
    lsu_op_e             op;
    logic [ADDR_W-1:0]   paddr;
    logic                except_valid;
    except_e             except_type;
    logic                wr_valid;
    logic [RNID_W-1:0]   wr_rnid;
    logic [REGIDX_W-1:0] wr_regidx;
    logic [XLEN_W-1:0]   data;
  } ex2_entry_t;

endpackage

`default_nettype wire

// ==== logic/lsu_ctrl_decoder.sv ====
/*
 * Load/store control decoder
 * Turns an instruction word into operation, size, sign and offset
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_decoder (
  input  lsu_pkg::lsu_inst_u i_inst,
  output lsu_pkg::lsu_ctrl_t o_ctrl,
  output logic signed [11:0] o_offset
);

  logic w_is_load;
  logic w_is_store;

  assign w_is_load  = (i_inst.ld.opcode == lsu_pkg::OPC_LOAD);
  // Stores only go up to SD
  assign w_is_store = (i_inst.st.opcode == lsu_pkg::OPC_STORE) & ~i_inst.st.funct3[2];

  always_comb begin
    if (w_is_load) begin
      o_ctrl.op = lsu_pkg::OP_LOAD;
    end else if (w_is_store) begin
      o_ctrl.op = lsu_pkg::OP_STORE;
    end else begin
      o_ctrl.op = lsu_pkg::OP_OTHER;
    end
    o_ctrl.size        = lsu_pkg::lsu_size_e'(i_inst.ld.funct3[1:0]);
    o_ctrl.is_unsigned = i_inst.ld.funct3[2];
  end

  // I-type immediate for loads, split S-type immediate for stores
  always_comb begin
    if (w_is_load) begin
      o_offset = $signed(i_inst.ld.imm);
    end else if (w_is_store) begin
      o_offset = $signed({i_inst.st.imm_hi, i_inst.st.imm_lo});
    end else begin
      o_offset = '0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/lsu_ex1_agen.sv ====
/*
 * EX1 address generation stage
 * Registers the issued instruction, forms the physical address,
 * checks alignment and sends the L1D read request
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_ex1_agen (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_flush,
  input  lsu_pkg::lsu_issue_t   i_issue,
  output lsu_pkg::l1d_req_t     o_l1d_req,
  output lsu_pkg::ex1_entry_t   o_ex1
);

  lsu_pkg::lsu_ctrl_t        w_ex0_ctrl;
  logic signed [11:0]        w_ex0_offset;

  logic                      r_ex1_valid;
  lsu_pkg::lsu_issue_t       r_ex1_issue;
  lsu_pkg::lsu_ctrl_t        r_ex1_ctrl;
  logic signed [11:0]        r_ex1_offset;

  logic [lsu_pkg::ADDR_W-1:0] w_ex1_addr;
  logic                      w_ex1_is_load;
  logic                      w_ex1_is_store;
  logic                      w_ex1_addr_ma;
  logic                      w_ex1_except_valid;
  lsu_pkg::except_e          w_ex1_except_type;

  lsu_ctrl_decoder u_ctrl_decoder (
    .i_inst   (i_issue.inst),
    .o_ctrl   (w_ex0_ctrl),
    .o_offset (w_ex0_offset)
  );

  // ----------------------------------------
  // EX0 to EX1 register
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue.valid & ~i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_issue  <= i_issue;
    r_ex1_ctrl   <= w_ex0_ctrl;
    r_ex1_offset <= w_ex0_offset;
  end

  // ----------------------------------------
  // Address and alignment
  // ----------------------------------------
  assign w_ex1_addr = r_ex1_issue.rs1_data[lsu_pkg::ADDR_W-1:0] +
                      {{(lsu_pkg::ADDR_W-12){r_ex1_offset[11]}}, r_ex1_offset};

  assign w_ex1_is_load  = (r_ex1_ctrl.op == lsu_pkg::OP_LOAD);
  assign w_ex1_is_store = (r_ex1_ctrl.op == lsu_pkg::OP_STORE);

  always_comb begin
    case (r_ex1_ctrl.size)
      lsu_pkg::SIZE_H:  w_ex1_addr_ma = w_ex1_addr[0];
      lsu_pkg::SIZE_W:  w_ex1_addr_ma = |w_ex1_addr[1:0];
      lsu_pkg::SIZE_DW: w_ex1_addr_ma = |w_ex1_addr[2:0];
      default:          w_ex1_addr_ma = 1'b0;
    endcase
  end

  // OP_OTHER never faults here
  assign w_ex1_except_valid = w_ex1_addr_ma & (w_ex1_is_load | w_ex1_is_store);
  assign w_ex1_except_type  = !w_ex1_except_valid ? lsu_pkg::EXC_NONE :
                              w_ex1_is_load       ? lsu_pkg::LOAD_ADDR_MISALIGN :
                                                    lsu_pkg::STAMO_ADDR_MISALIGN;

  // Word-aligned read for aligned loads only
  assign o_l1d_req.valid = r_ex1_valid & w_ex1_is_load & ~w_ex1_except_valid & ~i_flush;
  assign o_l1d_req.paddr = {w_ex1_addr[lsu_pkg::ADDR_W-1:$clog2(lsu_pkg::DW_BYTES)],
                            {$clog2(lsu_pkg::DW_BYTES){1'b0}}};

  assign o_ex1.valid        = r_ex1_valid;
  assign o_ex1.cmt_id       = r_ex1_issue.cmt_id;
  assign o_ex1.ctrl         = r_ex1_ctrl;
  assign o_ex1.paddr        = w_ex1_addr;
  assign o_ex1.except_valid = w_ex1_except_valid;
  assign o_ex1.except_type  = w_ex1_except_type;
  assign o_ex1.wr_valid     = r_ex1_issue.wr_valid;
  assign o_ex1.wr_rnid      = r_ex1_issue.wr_rnid;
  assign o_ex1.wr_regidx    = r_ex1_issue.wr_regidx;

endmodule

`default_nettype wire

// ==== logic/lsu_ex2_load_align.sv ====
/*
 * EX2 load data stage
 * Asks the store queue for forwarding, merges forwarded bytes over
 * L1D data, cuts and extends the load value, updates the store queue
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_ex2_load_align (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_flush,
  input  lsu_pkg::ex1_entry_t           i_ex1,
  input  logic [lsu_pkg::XLEN_W-1:0]    i_l1d_data,
  input  lsu_pkg::fwd_resp_t            i_fwd_resp,
  output lsu_pkg::fwd_req_t             o_fwd_req,
  output lsu_pkg::stq_upd_t             o_stq_upd,
  output lsu_pkg::ex2_entry_t           o_ex2
);

  logic                                  r_ex2_valid;
  lsu_pkg::ex1_entry_t                   r_ex2;

  logic                                  w_ex2_aligned;
  logic [$clog2(lsu_pkg::DW_BYTES)-1:0]  w_ofs;
  logic [lsu_pkg::DW_BYTES-1:0]          w_size_mask;
  logic [lsu_pkg::DW_BYTES-1:0]          w_fwd_dw_al;
  logic [lsu_pkg::XLEN_W-1:0]            w_l1d_al;
  logic [lsu_pkg::XLEN_W-1:0]            w_merged;
  logic                                  w_fill;
  logic [lsu_pkg::XLEN_W-1:0]            w_ext_data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_valid <= 1'b0;
    end else begin
      r_ex2_valid <= i_ex1.valid & ~i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2 <= i_ex1;
  end

  assign w_ex2_aligned = r_ex2_valid & ~r_ex2.except_valid & ~i_flush;
  assign w_ofs         = r_ex2.paddr[$clog2(lsu_pkg::DW_BYTES)-1:0];

  always_comb begin
    case (r_ex2.ctrl.size)
      lsu_pkg::SIZE_B: w_size_mask = 8'h01;
      lsu_pkg::SIZE_H: w_size_mask = 8'h03;
      lsu_pkg::SIZE_W: w_size_mask = 8'h0f;
      default:         w_size_mask = 8'hff;
    endcase
  end

  // ----------------------------------------
  // Store queue forwarding request
  // ----------------------------------------
  assign o_fwd_req.valid = w_ex2_aligned & (r_ex2.ctrl.op == lsu_pkg::OP_LOAD);
  assign o_fwd_req.paddr = r_ex2.paddr;
  assign o_fwd_req.dw    = w_size_mask << w_ofs;

  // ----------------------------------------
  // Byte merge
  // ----------------------------------------
  // Both sources moved down to the load's first byte
  assign w_fwd_dw_al = i_fwd_resp.fwd_dw >> w_ofs;
  assign w_l1d_al    = i_l1d_data >> {w_ofs, 3'b000};

  for (genvar b = 0; b < lsu_pkg::DW_BYTES; b++) begin : g_byte_merge
    assign w_merged[b*8 +: 8] = w_fwd_dw_al[b] ? i_fwd_resp.data[b*8 +: 8] :
                                                 w_l1d_al[b*8 +: 8];
  end

  // Size cut with sign or zero fill
  always_comb begin
    case (r_ex2.ctrl.size)
      lsu_pkg::SIZE_B: w_fill = w_merged[7];
      lsu_pkg::SIZE_H: w_fill = w_merged[15];
      lsu_pkg::SIZE_W: w_fill = w_merged[31];
      default:         w_fill = w_merged[63];
    endcase
    w_fill = w_fill & ~r_ex2.ctrl.is_unsigned;
    w_ext_data = {lsu_pkg::XLEN_W{w_fill}};
    case (r_ex2.ctrl.size)
      lsu_pkg::SIZE_B: w_ext_data[7:0]  = w_merged[7:0];
      lsu_pkg::SIZE_H: w_ext_data[15:0] = w_merged[15:0];
      lsu_pkg::SIZE_W: w_ext_data[31:0] = w_merged[31:0];
      default:         w_ext_data       = w_merged;
    endcase
  end

  // ----------------------------------------
  // Store queue address update
  // ----------------------------------------
  assign o_stq_upd.valid  = w_ex2_aligned & (r_ex2.ctrl.op == lsu_pkg::OP_STORE);
  assign o_stq_upd.cmt_id = r_ex2.cmt_id;
  assign o_stq_upd.paddr  = r_ex2.paddr;
  assign o_stq_upd.size   = r_ex2.ctrl.size;

  // A flush in this cycle keeps the entry out of EX3
  assign o_ex2.valid        = r_ex2_valid & ~i_flush;
  assign o_ex2.cmt_id       = r_ex2.cmt_id;
  assign o_ex2.op           = r_ex2.ctrl.op;
  assign o_ex2.paddr        = r_ex2.paddr;
  assign o_ex2.except_valid = r_ex2.except_valid;
  assign o_ex2.except_type  = r_ex2.except_type;
  assign o_ex2.wr_valid     = r_ex2.wr_valid;
  assign o_ex2.wr_rnid      = r_ex2.wr_rnid;
  assign o_ex2.wr_regidx    = r_ex2.wr_regidx;
  assign o_ex2.data         = w_ext_data;

endmodule

`default_nettype wire

// ==== logic/lsu_ex3_report.sv ====
/*
 * EX3 completion stage
 * Sends the done report and the register write-back
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_ex3_report (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  lsu_pkg::ex2_entry_t    i_ex2,
  output lsu_pkg::done_report_t  o_done,
  output lsu_pkg::phy_wr_t       o_phy_wr
);

  logic                 r_ex3_valid;
  lsu_pkg::ex2_entry_t  r_ex3;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex3_valid <= i_ex2.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex3 <= i_ex2;
  end

  // ----------------------------------------
  // Done report
  // ----------------------------------------
  assign o_done.valid        = r_ex3_valid;
  assign o_done.cmt_id       = r_ex3.cmt_id;
  assign o_done.except_valid = r_ex3.except_valid;
  assign o_done.except_type  = r_ex3.except_type;
  // Faulting physical address, zero extended
  assign o_done.tval         = r_ex3.except_valid ?
                               {{(lsu_pkg::XLEN_W-lsu_pkg::ADDR_W){1'b0}}, r_ex3.paddr} :
                               '0;

  // No write to x0
  assign o_phy_wr.valid = r_ex3_valid & (r_ex3.op == lsu_pkg::OP_LOAD) & r_ex3.wr_valid &
                          ~r_ex3.except_valid & (r_ex3.wr_regidx != '0);
  assign o_phy_wr.rnid  = r_ex3.wr_rnid;
  assign o_phy_wr.data  = r_ex3.data;

endmodule

`default_nettype wire

// ==== logic/lsu_pipe.sv ====
/*
 * RV64 load/store execution pipe, EX0 to EX3
 * Fixed three-cycle latency, no back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_flush,
  input  lsu_pkg::lsu_issue_t         i_issue,
  input  logic [lsu_pkg::XLEN_W-1:0]  i_l1d_data,
  input  lsu_pkg::fwd_resp_t          i_fwd_resp,
  output lsu_pkg::l1d_req_t           o_l1d_req,
  output lsu_pkg::fwd_req_t           o_fwd_req,
  output lsu_pkg::stq_upd_t           o_stq_upd,
  output lsu_pkg::done_report_t       o_done,
  output lsu_pkg::phy_wr_t            o_phy_wr
);

  lsu_pkg::ex1_entry_t w_ex1;
  lsu_pkg::ex2_entry_t w_ex2;

  lsu_ex1_agen u_ex1_agen (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),
    .i_issue   (i_issue),
    .o_l1d_req (o_l1d_req),
    .o_ex1     (w_ex1)
  );

  lsu_ex2_load_align u_ex2_load_align (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_flush    (i_flush),
    .i_ex1      (w_ex1),
    .i_l1d_data (i_l1d_data),
    .i_fwd_resp (i_fwd_resp),
    .o_fwd_req  (o_fwd_req),
    .o_stq_upd  (o_stq_upd),
    .o_ex2      (w_ex2)
  );

  lsu_ex3_report u_ex3_report (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_ex2     (w_ex2),
    .o_done    (o_done),
    .o_phy_wr  (o_phy_wr)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_lsu_pipe.sv ====
/*
 * Testbench for the RV64 load/store pipe
 * Random loads, stores and other opcodes with commit flushes, a word
 * memory and a store-queue forwarding model, checked against a
 * cycle-tagged queue of expected results
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_pipe;

  localparam int N_INSTR    = 2000;
  localparam int MAX_CYCLES = N_INSTR * 3 / 2;
  localparam int MEM_WORDS  = 512;

  typedef struct packed {
    int          issue;
    logic [5:0]  cmt_id;
    logic        is_load;
    logic        is_store;
    logic        mis;
    logic [31:0] addr;
    logic [1:0]  size;
    logic        uns;
    logic        wr_valid;
    logic [5:0]  rnid;
    logic [4:0]  regidx;
    logic [63:0] data;
  } exp_entry_t;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_flush;
  lsu_pkg::lsu_issue_t   i_issue;
  logic [63:0]           i_l1d_data;
  lsu_pkg::fwd_resp_t    i_fwd_resp;
  lsu_pkg::l1d_req_t     o_l1d_req;
  lsu_pkg::fwd_req_t     o_fwd_req;
  lsu_pkg::stq_upd_t     o_stq_upd;
  lsu_pkg::done_report_t o_done;
  lsu_pkg::phy_wr_t      o_phy_wr;

  logic [15:0] lfsr;
  logic [63:0] mem [0:MEM_WORDS-1];
  exp_entry_t  exp_q[$];
  int          cyc;
  int          issued;
  int          cycle_count;
  int          err_mem;
  int          err_done;
  int          err_wr;
  logic        l1d_pend;
  logic [8:0]  l1d_idx;
  logic [7:0]  fwd_mask;
  logic [63:0] fwd_data;
  int          a;

  lsu_pipe dut0 (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_flush    (i_flush),
    .i_issue    (i_issue),
    .i_l1d_data (i_l1d_data),
    .i_fwd_resp (i_fwd_resp),
    .o_l1d_req  (o_l1d_req),
    .o_fwd_req  (o_fwd_req),
    .o_stq_upd  (o_stq_upd),
    .o_done     (o_done),
    .o_phy_wr   (o_phy_wr)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic logic misaligned(input logic [31:0] addr, input logic [1:0] size);
    case (size)
      2'd1:    return addr[0];
      2'd2:    return addr[1:0] != 2'b00;
      2'd3:    return addr[2:0] != 3'b000;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [7:0] access_mask(input logic [1:0] size, input logic [2:0] ofs);
    logic [7:0] m;
    int         i;
    m = '0;
    for (i = 0; i < (1 << size); i++) begin
      m[int'(ofs) + i] = 1'b1;
    end
    return m;
  endfunction

  // Forwarded lanes win over memory lanes before size cut and extension
  function automatic logic [63:0] load_value(input logic [63:0] word, input logic [7:0] mask,
                                             input logic [63:0] fdata, input logic [2:0] ofs,
                                             input logic [1:0] size, input logic uns);
    logic [63:0] v;
    int          nbytes;
    int          lane;
    int          i;
    nbytes = 1 << size;
    v = '0;
    for (i = 0; i < nbytes; i++) begin
      lane = int'(ofs) + i;
      if (mask[lane]) begin
        v[i*8 +: 8] = fdata[i*8 +: 8];
      end else begin
        v[i*8 +: 8] = word[lane*8 +: 8];
      end
    end
    if (!uns && v[nbytes*8-1]) begin
      for (i = nbytes * 8; i < 64; i++) begin
        v[i] = 1'b1;
      end
    end
    return v;
  endfunction

  function automatic int find_entry(input int issue);
    int idx;
    idx = -1;
    foreach (exp_q[i]) begin
      if (exp_q[i].issue == issue) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic report_mismatch(input int kind, input string what, input int issue);
    case (kind)
      0:       err_mem++;
      1:       err_done++;
      default: err_wr++;
    endcase
    $display("[ERROR] %0t: %s wrong for instruction issued in cycle %0d", $time, what, issue);
  endtask

  // ----------------------------------------
  // Stimulus and memory side
  // ----------------------------------------
  task automatic drive_inputs(input logic active);
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [4:0]  rs1_idx;
    logic [4:0]  rs2_idx;
    logic [31:0] word;
    logic [31:0] base;
    exp_entry_t  e;
    int          i;
    kind    = 3'(rand_bits(3));
    f3      = 3'(rand_bits(3));
    imm     = 12'(rand_bits(12));
    base    = {20'h80000, 12'(rand_bits(12))};
    rs1_idx = 5'(rand_bits(5));
    rs2_idx = 5'(rand_bits(5));
    rd      = 5'(rand_bits(5));
    // Keep plenty of aligned accesses
    if (rand_bits(1) != '0) begin
      imm[2:0]  = 3'b000;
      base[2:0] = 3'b000;
    end
    if (rand_bits(3) == '0) begin
      rd = 5'd0;
    end
    if (kind < 3'd4) begin
      opc = lsu_pkg::OPC_LOAD;
    end else if (kind < 3'd6) begin
      opc   = lsu_pkg::OPC_STORE;
      f3[2] = 1'b0;
    end else if (kind == 3'd6) begin
      opc   = lsu_pkg::OPC_STORE;
      f3[2] = 1'b1;
    end else begin
      opc = 7'(rand_bits(7));
      if (opc == lsu_pkg::OPC_LOAD || opc == lsu_pkg::OPC_STORE) begin
        opc = opc ^ 7'h10;
      end
    end
    if (opc == lsu_pkg::OPC_STORE) begin
      word = {imm[11:5], rs2_idx, rs1_idx, f3, imm[4:0], opc};
    end else begin
      word = {imm, rs1_idx, f3, rd, opc};
    end

    i_issue.valid     = active && (rand_bits(3) != '0);
    i_issue.cmt_id    = 6'(rand_bits(6));
    i_issue.inst      = word;
    i_issue.rs1_data  = {32'(rand_bits(32)), base};
    i_issue.wr_valid  = rand_bits(3) != '0;
    i_issue.wr_rnid   = 6'(rand_bits(6));
    i_issue.wr_regidx = rd;
    i_flush           = active && (rand_bits(4) == '0);
    i_l1d_data        = l1d_pend ? mem[l1d_idx] : 64'h0;

    if (i_issue.valid) begin
      e.issue    = cyc;
      e.cmt_id   = i_issue.cmt_id;
      e.is_load  = opc == lsu_pkg::OPC_LOAD;
      e.is_store = (opc == lsu_pkg::OPC_STORE) && !f3[2];
      e.addr     = base + {{20{imm[11]}}, imm};
      e.size     = f3[1:0];
      e.uns      = f3[2];
      e.mis      = (e.is_load || e.is_store) && misaligned(e.addr, f3[1:0]);
      e.wr_valid = i_issue.wr_valid;
      e.rnid     = i_issue.wr_rnid;
      e.regidx   = rd;
      e.data     = '0;
      exp_q.push_back(e);
      issued++;
    end
    // Flush kills EX0, EX1 and EX2
    if (i_flush) begin
      for (i = exp_q.size() - 1; i >= 0; i--) begin
        if (exp_q[i].issue >= cyc - 2) begin
          exp_q.delete(i);
        end
      end
    end
  endtask

  task automatic answer_forwarding();
    fwd_mask = 8'(rand_bits(8));
    fwd_data = rand_bits(64);
    if (!o_fwd_req.valid) begin
      fwd_mask = '0;
    end
    fwd_mask = fwd_mask & o_fwd_req.dw;
    i_fwd_resp.fwd_dw = fwd_mask;
    i_fwd_resp.data   = fwd_data;
  endtask

  // ----------------------------------------
  // Checker
  // ----------------------------------------
  task automatic check_outputs();
    exp_entry_t       e;
    int               k;
    logic             exp_v;
    lsu_pkg::except_e exp_exc;

    k = find_entry(cyc - 1);
    if (k >= 0) begin
      e = exp_q[k];
    end
    exp_v = (k >= 0) && e.is_load && !e.mis;
    assert (o_l1d_req.valid == exp_v) else report_mismatch(0, "L1D request valid", cyc - 1);
    if (exp_v) begin
      assert (o_l1d_req.paddr == {e.addr[31:3], 3'b000})
        else report_mismatch(0, "L1D request address", cyc - 1);
    end
    l1d_pend = o_l1d_req.valid;
    l1d_idx  = o_l1d_req.paddr[11:3];

    k = find_entry(cyc - 2);
    if (k >= 0) begin
      e = exp_q[k];
    end
    exp_v = (k >= 0) && e.is_load && !e.mis;
    assert (o_fwd_req.valid == exp_v) else report_mismatch(0, "Forward request valid", cyc - 2);
    if (exp_v) begin
      assert (o_fwd_req.paddr == e.addr) else report_mismatch(0, "Forward address", cyc - 2);
      assert (o_fwd_req.dw == access_mask(e.size, e.addr[2:0]))
        else report_mismatch(0, "Forward byte mask", cyc - 2);
      e.data = load_value(mem[e.addr[11:3]], fwd_mask, fwd_data, e.addr[2:0], e.size, e.uns);
      exp_q[k] = e;
    end
    exp_v = (k >= 0) && e.is_store && !e.mis;
    assert (o_stq_upd.valid == exp_v) else report_mismatch(0, "Store update valid", cyc - 2);
    if (exp_v) begin
      assert (o_stq_upd.cmt_id == e.cmt_id && o_stq_upd.paddr == e.addr &&
              o_stq_upd.size == e.size)
        else report_mismatch(0, "Store update fields", cyc - 2);
    end

    k = find_entry(cyc - 3);
    if (k >= 0) begin
      e = exp_q[k];
    end
    assert (o_done.valid == (k >= 0)) else report_mismatch(1, "Done valid", cyc - 3);
    if (k >= 0) begin
      exp_exc = !e.mis ? lsu_pkg::EXC_NONE :
                e.is_load ? lsu_pkg::LOAD_ADDR_MISALIGN : lsu_pkg::STAMO_ADDR_MISALIGN;
      assert (o_done.cmt_id == e.cmt_id) else report_mismatch(1, "Done cmt_id", cyc - 3);
      assert (o_done.except_valid == e.mis && o_done.except_type == exp_exc)
        else report_mismatch(1, "Exception", cyc - 3);
      assert (o_done.tval == (e.mis ? {32'h0, e.addr} : 64'h0))
        else report_mismatch(1, "Exception tval", cyc - 3);
    end
    exp_v = (k >= 0) && e.is_load && e.wr_valid && !e.mis && (e.regidx != 5'd0);
    assert (o_phy_wr.valid == exp_v) else report_mismatch(2, "Write-back valid", cyc - 3);
    if (exp_v) begin
      assert (o_phy_wr.rnid == e.rnid) else report_mismatch(2, "Write-back rnid", cyc - 3);
      assert (o_phy_wr.data == e.data) else report_mismatch(2, "Load data", cyc - 3);
    end
    if (k >= 0) begin
      exp_q.delete(k);
    end
  endtask

  task automatic run_cycle(input logic active);
    @(posedge i_clk);
    #1;
    cyc++;
    drive_inputs(active);
    #1;
    answer_forwarding();
    #1;
    check_outputs();
  endtask

  // Run limit
  always @(posedge i_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    i_reset_n   = 1'b0;
    i_flush     = 1'b0;
    i_issue     = '0;
    i_l1d_data  = '0;
    i_fwd_resp  = '0;
    lfsr        = 16'd8;
    cyc         = 0;
    issued      = 0;
    cycle_count = 0;
    err_mem     = 0;
    err_done    = 0;
    err_wr      = 0;
    l1d_pend    = 1'b0;
    l1d_idx     = '0;
    fwd_mask    = '0;
    fwd_data    = '0;
    for (a = 0; a < MEM_WORDS; a++) begin
      mem[a] = rand_bits(64);
    end

    repeat (5) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;

    while (issued < N_INSTR) begin
      run_cycle(1'b1);
    end
    // Drain the pipe
    repeat (4) run_cycle(1'b0);

    $display("Errors: memory side %0d, done report %0d, write-back %0d",
             err_mem, err_done, err_wr);
    if (err_mem + err_done + err_wr == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/lsu_pkg.sv
logic/lsu_ctrl_decoder.sv
logic/lsu_ex1_agen.sv
logic/lsu_ex2_load_align.sv
logic/lsu_ex3_report.sv
logic/lsu_pipe.sv
testbench/tb_lsu_pipe.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the LSU pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module tb_lsu_pipe; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_lsu_pipe)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
